//--- audio/i2s_silence_gen.sv
//////////////////////////////////////////////////////////////////////
// silent I2S stream clocked from the master clock
// sclk = mclk / 4, lrck flips every 32 bit clocks
// the data line never leaves zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module i2s_silence_gen
    import audio_pkg::*;
(
    input  logic audgen_mclk,
    input  logic reset_n,
    output logic audio_sclk,
    output logic audio_lrck,
    output logic audio_dac
);

    //////////////////////////////////////////////////////////////////////
    // bit clock divider
    //////////////////////////////////////////////////////////////////////

    sclk_div_t sclk_div;

    // divider at its last count, next edge is a falling sclk edge
    logic sclk_fall;

    assign sclk_fall = (sclk_div == sclk_div_t'(mclk_per_sclk - 1));

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            sclk_div <= '0;
        end else begin
            // free running, wraps 3 -> 0
            sclk_div <= sclk_div + sclk_div_t'(1);
        end
    end

    // top bit: low for counts 0-1, high for 2-3
    assign audio_sclk = sclk_div[1];

    //////////////////////////////////////////////////////////////////////
    // slot counter and channel select
    //////////////////////////////////////////////////////////////////////

    slot_count_t slot_count;

    // last bit of the current channel
    logic slot_last;

    assign slot_last = (slot_count == slot_count_t'(sclk_per_channel - 1));

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            slot_count <= '0;
            audio_lrck <= 1'b0;
            audio_dac  <= 1'b0;
        end else begin
            // silent sample bits
            audio_dac <= 1'b0;
            if (sclk_fall) begin
                slot_count <= slot_count + slot_count_t'(1);
                // switch channels at the end of the slot
                if (slot_last) begin
                    audio_lrck <= ~audio_lrck;
                end
            end
        end
    end

endmodule

//--- bench/tb_core_av.sv
//////////////////////////////////////////////////////////////////////
// directed testbench for core_av_top
// pixel_in is random from a fixed seed, one new value per clock
// outputs are sampled on the falling clock edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_core_av
    import video_pkg::*;
    import audio_pkg::*;
();

    localparam int unsigned clk_period   = 4;
    localparam int unsigned frame_clocks = h_total * v_total;
    localparam int unsigned lrck_half    = mclk_per_sclk * sclk_per_channel;
    // three frames covers every test with margin
    localparam int unsigned watchdog_ns  = 3 * frame_clocks * clk_period;
    localparam logic [31:0] random_seed  = 32'he35c_da3c;

    logic        audgen_mclk;
    logic        reset_n;
    pixel444_t   pixel_in;
    logic        pixel_visible;
    rgb888_t     video_rgb;
    logic        video_de;
    logic        video_hs;
    logic        video_vs;
    logic        audio_mclk;
    logic        audio_sclk;
    logic        audio_lrck;
    logic        audio_dac;

    // exp_pixel is the colour due on the current output
    pixel444_t   prev_pixel;
    pixel444_t   exp_pixel;
    logic [31:0] rnd;
    int          fail_count = 0;
    int          pass_count = 0;
    int          test_errors = 0;

    core_av_top i_dut (
        .audgen_mclk   (audgen_mclk),
        .reset_n       (reset_n),
        .pixel_in      (pixel_in),
        .pixel_visible (pixel_visible),
        .video_rgb     (video_rgb),
        .video_de      (video_de),
        .video_hs      (video_hs),
        .video_vs      (video_vs),
        .audio_mclk    (audio_mclk),
        .audio_sclk    (audio_sclk),
        .audio_lrck    (audio_lrck),
        .audio_dac     (audio_dac)
    );

    initial audgen_mclk = 1'b0;
    always #(clk_period / 2) audgen_mclk = ~audgen_mclk;

    // pixel source drives a new value 0.5 ns after each rising edge
    initial begin
        pixel_in   = '0;
        prev_pixel = '0;
        exp_pixel  = '0;
        rnd        = $urandom(random_seed);
        forever begin
            @(posedge audgen_mclk);
            #0.5;
            exp_pixel  = prev_pixel;
            prev_pixel = pixel_in;
            rnd        = $urandom();
            pixel_in   = rnd[11:0];
        end
    end

    initial begin
        #(watchdog_ns);
        $display("timeout, the tests did not finish within three frames");
        $display("Regression failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s expected 'h%0h actual 'h%0h", name, expected, actual);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        fail_count++;
        test_errors++;
    endtask

    task automatic report_test(input string name);
        $display("%s finished with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    // everything low except vsync, which may be expected high
    task automatic check_quiet_outputs(input string name, input logic exp_vs);
        check_value({name, " video_de"}, 32'd0, 32'(video_de));
        check_value({name, " video_hs"}, 32'd0, 32'(video_hs));
        check_value({name, " video_vs"}, 32'(exp_vs), 32'(video_vs));
        check_value({name, " video_rgb"}, 32'd0, 32'(video_rgb));
        check_value({name, " pixel_visible"}, 32'd0, 32'(pixel_visible));
        check_value({name, " audio_sclk"}, 32'd0, 32'(audio_sclk));
        check_value({name, " audio_lrck"}, 32'd0, 32'(audio_lrck));
        check_value({name, " audio_dac"}, 32'd0, 32'(audio_dac));
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        repeat (4) begin
            @(negedge audgen_mclk);
            check_quiet_outputs("test_reset", 1'b0);
        end
        // release after the fifth rising edge
        @(posedge audgen_mclk);
        #0.5;
        reset_n = 1'b1;
        @(negedge audgen_mclk);
        check_quiet_outputs("test_reset", 1'b0);
        // first edge registers the frame origin, so vsync is up
        @(negedge audgen_mclk);
        check_quiet_outputs("test_reset", 1'b1);
        report_test("test_reset");
    endtask

    task automatic test_line_timing();
        int   c;
        int   last_hs;
        int   de_start;
        int   hs_seen;
        int   lines_checked;
        logic prev_hs;
        logic prev_de;
        last_hs       = -1;
        de_start      = -1;
        hs_seen       = 0;
        lines_checked = 0;
        prev_hs       = 1'b0;
        prev_de       = 1'b0;
        // 14 lines reaches past the top border into the picture
        for (c = 0; c < 14 * h_total; c++) begin
            @(negedge audgen_mclk);
            if (video_hs) begin
                check_value("test_line_timing hs width", 32'd0, 32'(prev_hs));
                if (last_hs >= 0) begin
                    check_value("test_line_timing hs period", h_total, c - last_hs);
                end
                last_hs = c;
                hs_seen++;
            end
            if (video_de && !prev_de && last_hs >= 0) begin
                check_value("test_line_timing de after hs", h_bporch - h_sync_x, c - last_hs);
                de_start = c;
            end
            if (!video_de && prev_de && de_start >= 0) begin
                check_value("test_line_timing de length", h_active, c - de_start);
                lines_checked++;
            end
            prev_hs = video_hs;
            prev_de = video_de;
        end
        if (hs_seen < 2 || lines_checked == 0) begin
            note_failure("test_line_timing did not see two hsync pulses and an active line");
        end
        report_test("test_line_timing");
    endtask

    task automatic test_frame_timing();
        int   c;
        int   vs_at;
        int   vs_seen;
        int   active_lines;
        logic prev_de;
        vs_at        = -1;
        vs_seen      = 0;
        active_lines = 0;
        prev_de      = 1'b0;
        for (c = 0; c < 2 * frame_clocks + 8 && vs_seen < 2; c++) begin
            @(negedge audgen_mclk);
            check_value("test_frame_timing pixel_visible", 32'(video_de), 32'(pixel_visible));
            if (video_vs) begin
                if (vs_seen == 1) begin
                    check_value("test_frame_timing vs period", frame_clocks, c - vs_at);
                    check_value("test_frame_timing active lines", v_active, active_lines);
                end
                vs_at = c;
                vs_seen++;
            end else if (vs_seen == 1 && video_de && !prev_de) begin
                active_lines++;
                // line index of the first picture line, counted from vsync
                if (active_lines == 1) begin
                    check_value("test_frame_timing first active line", v_bporch,
                                (c - vs_at) / int'(h_total));
                end
            end
            prev_de = video_de;
        end
        if (vs_seen < 2) begin
            note_failure("test_frame_timing did not see two vsync pulses within two frames");
        end
        report_test("test_frame_timing");
    endtask

    task automatic test_pixel_path();
        int      c;
        int      de_clocks;
        rgb888_t exp_rgb;
        de_clocks = 0;
        for (c = 0; c < 14 * h_total; c++) begin
            @(negedge audgen_mclk);
            if (video_de) begin
                // each colour in the upper nibble of its byte
                exp_rgb = {exp_pixel.r, 4'h0, exp_pixel.g, 4'h0, exp_pixel.b, 4'h0};
                de_clocks++;
            end else begin
                exp_rgb = '0;
            end
            check_value("test_pixel_path video_rgb", 32'(exp_rgb), 32'(video_rgb));
        end
        if (de_clocks == 0) begin
            note_failure("test_pixel_path saw no active pixels");
        end
        report_test("test_pixel_path");
    endtask

    task automatic test_audio_framing();
        int   c;
        int   last_rise;
        int   last_lr;
        int   rises;
        int   lr_changes;
        logic prev_sclk;
        logic prev_lrck;
        last_rise  = -1;
        last_lr    = -1;
        rises      = 0;
        lr_changes = 0;
        // master clock follows audgen_mclk, sampled mid-phase
        repeat (4) begin
            @(posedge audgen_mclk);
            #1;
            check_value("test_audio_framing audio_mclk high", 32'd1, 32'(audio_mclk));
            @(negedge audgen_mclk);
            #1;
            check_value("test_audio_framing audio_mclk low", 32'd0, 32'(audio_mclk));
        end
        @(negedge audgen_mclk);
        prev_sclk = audio_sclk;
        prev_lrck = audio_lrck;
        for (c = 1; c <= 3 * lrck_half + 8; c++) begin
            @(negedge audgen_mclk);
            check_value("test_audio_framing audio_dac", 32'd0, 32'(audio_dac));
            if (audio_sclk && !prev_sclk) begin
                if (last_rise >= 0) begin
                    check_value("test_audio_framing sclk period", mclk_per_sclk, c - last_rise);
                end
                last_rise = c;
                rises++;
            end
            if (audio_lrck != prev_lrck) begin
                // channel select moves only with a falling bit clock
                check_value("test_audio_framing lrck on sclk fall", 32'd1,
                            32'(prev_sclk && !audio_sclk));
                if (last_lr >= 0) begin
                    check_value("test_audio_framing lrck half period", lrck_half, c - last_lr);
                end
                last_lr = c;
                lr_changes++;
            end
            prev_sclk = audio_sclk;
            prev_lrck = audio_lrck;
        end
        if (rises < 2 || lr_changes < 2) begin
            note_failure("test_audio_framing saw too few bit clock or channel select edges");
        end
        report_test("test_audio_framing");
    endtask

    initial begin
        reset_n = 1'b0;
        test_reset();
        test_line_timing();
        test_frame_timing();
        test_pixel_path();
        test_audio_framing();
        $display("checks passed %0d, checks failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- common/audio_pkg.sv
//////////////////////////////////////////////////////////////////////
// I2S framing for the silent audio path
// bit clock is mclk / 4, 32 bit clocks per channel slot
//////////////////////////////////////////////////////////////////////

package audio_pkg;

    // master clocks per bit clock
    localparam int unsigned mclk_per_sclk = 4;

    // bit clocks per channel slot, 64 per stereo frame
    localparam int unsigned sclk_per_channel = 32;

    // divider from mclk to sclk
    // top bit is the bit clock itself
    typedef logic [1:0] sclk_div_t;

    // bit position inside one channel slot
    typedef logic [4:0] slot_count_t;

endpackage

//--- common/video_pkg.sv
//////////////////////////////////////////////////////////////////////
// raster constants and types for the video path
// the raster is fixed at 292 clocks x 870 lines, one pixel per clock
// counters are 10 bits wide, so the totals must stay below 1024
//////////////////////////////////////////////////////////////////////

package video_pkg;

    //////////////////////////////////////////////////////////////////////
    // horizontal raster, in clocks
    //////////////////////////////////////////////////////////////////////

    // full line including blanking
    localparam int unsigned h_total  = 292;
    // blank clocks ahead of the active window
    localparam int unsigned h_bporch = 10;
    // visible pixels per line
    localparam int unsigned h_active = 256;
    // hsync position, kept off clock 0 so it never lands on vsync
    localparam int unsigned h_sync_x = 3;

    //////////////////////////////////////////////////////////////////////
    // vertical raster, in lines
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned v_total  = 870;
    localparam int unsigned v_bporch = 10;
    localparam int unsigned v_active = 240;

    // horizontal or vertical position
    typedef logic [9:0] raster_count_t;

    // colour from the pixel source, 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } pixel444_t;

    // output colour, red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb888_t;

    // per-clock raster state
    typedef struct packed {
        logic de;
        logic hs;
        logic vs;
    } video_sync_t;

endpackage

//--- project.f
common/video_pkg.sv
common/audio_pkg.sv
video/video_timing.sv
video/video_output.sv
audio/i2s_silence_gen.sv
verilog/core_av_top.sv
bench/tb_core_av.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the core_av testbench with Verilator
# the run passes only if the log holds the pass message

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=sim_core_av
log_file=sim.log

verilator --binary --timing \
    -f project.f \
    --top-module tb_core_av \
    --Mdir "$build_dir" \
    -o "$sim_bin"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Regression passed" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1

//--- verilog/core_av_top.sv
//////////////////////////////////////////////////////////////////////
// video timing, video output stage and silent I2S on one clock
// pixel source is external; pixel_visible marks the pixel on screen
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_av_top
    import video_pkg::*;
(
    input  logic      audgen_mclk,
    input  logic      reset_n,
    // pixel source
    input  pixel444_t pixel_in,
    output logic      pixel_visible,
    // video pins
    output rgb888_t   video_rgb,
    output logic      video_de,
    output logic      video_hs,
    output logic      video_vs,
    // audio pins
    output logic      audio_mclk,
    output logic      audio_sclk,
    output logic      audio_lrck,
    output logic      audio_dac
);

    // combinational raster state
    video_sync_t raster;

    video_timing i_video_timing (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .raster      (raster)
    );

    video_output i_video_output (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .raster      (raster),
        .pixel_in    (pixel_in),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs)
    );

    // visible flag back to the pixel source
    assign pixel_visible = video_de;

    i2s_silence_gen i_i2s_silence_gen (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

    // master clock straight out
    assign audio_mclk = audgen_mclk;

endmodule

//--- video/video_output.sv
//////////////////////////////////////////////////////////////////////
// pixel capture and registered video outputs
// pixel_in is sampled every clock; the value shown is the one
// captured on the previous edge. blanking forces black
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module video_output
    import video_pkg::*;
(
    input  logic        audgen_mclk,
    input  logic        reset_n,
    input  video_sync_t raster,
    input  pixel444_t   pixel_in,
    output rgb888_t     video_rgb,
    output logic        video_de,
    output logic        video_hs,
    output logic        video_vs
);

    // 4-bit colour into the upper nibble, low nibble zero
    function automatic rgb888_t expand_444(input pixel444_t px);
        rgb888_t rgb;
        rgb = '0;
        rgb[23:20] = px.r;
        rgb[15:12] = px.g;
        rgb[7:4]   = px.b;
        return rgb;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // pixel capture
    //////////////////////////////////////////////////////////////////////

    // payload only
    pixel444_t pixel_q;

    always_ff @(posedge audgen_mclk) begin
        pixel_q <= pixel_in;
    end

    //////////////////////////////////////////////////////////////////////
    // output registers
    //////////////////////////////////////////////////////////////////////

    // registered raster state
    video_sync_t sync_q;
    rgb888_t     rgb_q;

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            sync_q <= '0;
            rgb_q  <= '0;
        end else begin
            sync_q <= raster;
            // black outside the active window
            if (raster.de) begin
                rgb_q <= expand_444(pixel_q);
            end else begin
                rgb_q <= '0;
            end
        end
    end

    // pins
    assign video_rgb = rgb_q;
    assign video_de  = sync_q.de;
    assign video_hs  = sync_q.hs;
    assign video_vs  = sync_q.vs;

endmodule

//--- video/video_timing.sv
//////////////////////////////////////////////////////////////////////
// raster counters and sync / active-window decode
// raster output is combinational from the counters; register it
// downstream before it reaches any pin
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module video_timing
    import video_pkg::*;
(
    input  logic        audgen_mclk,
    input  logic        reset_n,
    output video_sync_t raster
);

    //////////////////////////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////////////////////////

    // current column and line
    raster_count_t h_count;
    raster_count_t v_count;

    // wrap points
    logic line_end;
    logic frame_end;

    assign line_end  = (h_count == raster_count_t'(h_total - 1));
    assign frame_end = (v_count == raster_count_t'(v_total - 1));

    // column advances every clock
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            h_count <= '0;
        end else if (line_end) begin
            h_count <= '0;
        end else begin
            h_count <= h_count + raster_count_t'(1);
        end
    end

    // line advances once per horizontal wrap
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            v_count <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + raster_count_t'(1);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    // inside the 256 visible columns
    logic h_in_window;
    // inside the 240 visible lines
    logic v_in_window;

    assign h_in_window = (h_count >= raster_count_t'(h_bporch)) &&
                         (h_count <  raster_count_t'(h_bporch + h_active));

    assign v_in_window = (v_count >= raster_count_t'(v_bporch)) &&
                         (v_count <  raster_count_t'(v_bporch + v_active));

    always_comb begin
        // frame origin only
        raster.vs = (h_count == '0) && (v_count == '0);
        // a few clocks into every line, never on the vsync clock
        raster.hs = (h_count == raster_count_t'(h_sync_x));
        // active picture
        raster.de = h_in_window && v_in_window;
    end

endmodule
